// ==== source/cnn_cfg.svh ====
`ifndef CNN_CFG_SVH
`define CNN_CFG_SVH

// Datapath widths
`define PIX_W   8    // Unsigned pixel
`define WGT_W   8    // Signed weight
`define ACC_W   24   // Signed result
`define BIAS_W  20
`define SHIFT_W 5

// Kernel and image geometry
`define KER_N   9
`define IMG_W   8
`define COL_W   3    // Holds 0 .. IMG_W-1
`define ROW_W   16

// Instruction word
`define INST_W  32

`endif

// ==== source/cnn_pkg.sv ====
`include "cnn_cfg.svh"

package cnn_pkg;

	typedef logic [`PIX_W-1:0] pixel_t;
	typedef logic signed [`WGT_W-1:0] weight_t;
	typedef logic signed [`ACC_W-1:0] acc_t;
	typedef logic signed [`BIAS_W-1:0] bias_t;
	typedef logic [`SHIFT_W-1:0] shift_t;

	// Bits 31..30 of every instruction
	typedef enum logic [1:0] {
		op_nop         = 2'd0,
		op_load_weight = 2'd1,
		op_load_bias   = 2'd2,
		op_conv        = 2'd3
	} opcode_t;

	// Bit 16 of a conv instruction
	typedef enum logic {
		pool_none = 1'b0,
		pool_max  = 1'b1
	} pool_mode_t;

endpackage

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module inst_decoder (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [`INST_W-1:0]   instruct,
	input  logic                 inst_empty,
	input  logic                 pix_valid,
	input  logic                 res_last,
	output logic                 inst_req,
	output logic                 pix_ready,
	output logic                 frame_start,
	output cnn_pkg::pool_mode_t  pool_mode,
	output logic [`ROW_W-1:0]    rows,
	output logic                 wgt_we,
	output logic [3:0]           wgt_idx,
	output cnn_pkg::weight_t     wgt_value,
	output logic                 bias_we,
	output cnn_pkg::bias_t       bias_value,
	output cnn_pkg::shift_t      shift_value,
	output logic                 frame_done
);
	import cnn_pkg::*;

	typedef enum logic [2:0] {st_idle, st_fetch, st_decode, st_run, st_drain} state_t;

	state_t state;
	opcode_t op;
	logic [`ROW_W+`COL_W-1:0] pix_cnt;
	logic [`ROW_W+`COL_W-1:0] pix_total;

	assign op = opcode_t'(instruct[31:30]);
	assign pix_total = rows * `IMG_W;

	//////////////////////////////
	// Control FSM
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			inst_req <= 1'b0;
			pix_ready <= 1'b0;
			frame_start <= 1'b0;
			frame_done <= 1'b0;
			wgt_we <= 1'b0;
			bias_we <= 1'b0;
			pool_mode <= pool_none;
			rows <= '0;
			pix_cnt <= '0;
		end else begin
			inst_req <= 1'b0;
			frame_start <= 1'b0;
			frame_done <= 1'b0;
			wgt_we <= 1'b0;
			bias_we <= 1'b0;
			case (state)
				st_idle: begin
					if (!inst_empty) begin
						inst_req <= 1'b1;
						state <= st_fetch;
					end
				end
				st_fetch: state <= st_decode;  // FIFO drives instruct next
				st_decode: begin
					state <= st_idle;
					case (op)
						op_load_weight: wgt_we <= 1'b1;
						op_load_bias: bias_we <= 1'b1;
						op_conv: begin
							frame_start <= 1'b1;
							pool_mode <= pool_mode_t'(instruct[16]);
							rows <= instruct[15:0];
							pix_cnt <= '0;
							state <= st_run;
						end
						default: ;  // op_nop
					endcase
				end
				st_run: begin
					if (frame_start)
						pix_ready <= 1'b1;  // Window counters cleared first
					if (pix_ready && pix_valid) begin
						pix_cnt <= pix_cnt + 1'b1;
						if (pix_cnt == pix_total - 1'b1) begin
							pix_ready <= 1'b0;
							state <= st_drain;
						end
					end
				end
				st_drain: begin
					if (res_last) begin
						frame_done <= 1'b1;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// Load fields
	always_ff @(posedge clk) begin
		if (state == st_decode) begin
			wgt_idx <= instruct[27:24];
			wgt_value <= instruct[7:0];
			bias_value <= instruct[19:0];
			shift_value <= instruct[24:20];
		end
	end

endmodule

// ==== source/kernel_buffer.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module kernel_buffer (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              wgt_we,
	input  logic [3:0]        wgt_idx,
	input  cnn_pkg::weight_t  wgt_value,
	input  logic              bias_we,
	input  cnn_pkg::bias_t    bias_value,
	input  cnn_pkg::shift_t   shift_value,
	output cnn_pkg::weight_t  weights [`KER_N],
	output cnn_pkg::bias_t    bias,
	output cnn_pkg::shift_t   shift
);

	// Taps in row-major order, tap 0 is top-left of oldest row
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < `KER_N; k++) begin
				weights[k] <= '0;
			end
		end else if (wgt_we && wgt_idx < `KER_N) begin
			weights[wgt_idx] <= wgt_value;  // Out of range index dropped
		end
	end

	// Shift travels with the bias
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bias <= '0;
			shift <= '0;
		end else if (bias_we) begin
			bias <= bias_value;
			shift <= shift_value;
		end
	end

endmodule

// ==== source/line_window.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module line_window (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               frame_start,
	input  logic               pix_ready,
	input  logic               pix_valid,
	input  cnn_pkg::pixel_t    pix_data,
	input  logic [`ROW_W-1:0]  rows,
	output logic               win_valid,
	output logic               win_last,
	output cnn_pkg::pixel_t    window [3][3]
);
	import cnn_pkg::*;

	pixel_t line0 [`IMG_W];  // Previous row
	pixel_t line1 [`IMG_W];  // Two rows back
	logic [`COL_W-1:0] col;
	logic [`ROW_W-1:0] row;
	logic take;

	assign take = pix_valid && pix_ready;

	//////////////////////////////
	// Line memories and window

	always_ff @(posedge clk) begin
		if (take) begin
			line1[col] <= line0[col];
			line0[col] <= pix_data;
		end
	end

	// Row 0 of the window is the oldest row
	always_ff @(posedge clk) begin
		if (take) begin
			for (int r = 0; r < 3; r++) begin
				window[r][0] <= window[r][1];
				window[r][1] <= window[r][2];
			end
			window[0][2] <= line1[col];
			window[1][2] <= line0[col];
			window[2][2] <= pix_data;
		end
	end

	//////////////////////////////
	// Position tracking

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			col <= '0;
			row <= '0;
			win_valid <= 1'b0;
			win_last <= 1'b0;
		end else begin
			win_valid <= 1'b0;
			win_last <= 1'b0;
			if (frame_start) begin
				col <= '0;
				row <= '0;
			end else if (take) begin
				// Valid convolution only, no padding
				win_valid <= (row >= 2) && (col >= 2);
				win_last <= (row == rows - 1'b1) && (col == `IMG_W - 1);
				if (col == `IMG_W - 1) begin
					col <= '0;
					row <= row + 1'b1;
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

endmodule

// ==== source/conv_engine.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module conv_engine (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              win_valid,
	input  logic              win_last,
	input  cnn_pkg::pixel_t   window [3][3],
	input  cnn_pkg::weight_t  weights [`KER_N],
	input  cnn_pkg::bias_t    bias,
	input  cnn_pkg::shift_t   shift,
	output logic              conv_valid,
	output logic              conv_last,
	output cnn_pkg::acc_t     conv_data
);

	localparam int PROD_W = `PIX_W + `WGT_W + 1;
	localparam int SUM_W = `ACC_W + 8;  // Headroom before truncation

	logic signed [PROD_W-1:0] prod [`KER_N];
	logic signed [SUM_W-1:0] sum;
	logic signed [SUM_W-1:0] scaled;
	logic v1;
	logic l1;

	//////////////////////////////
	// Stage 1 products
	always_ff @(posedge clk) begin
		for (int k = 0; k < `KER_N; k++) begin
			prod[k] <= $signed({1'b0, window[k / 3][k % 3]}) * weights[k];
		end
	end

	//////////////////////////////
	// Stage 2 sum, bias, shift
	always_comb begin
		sum = bias;
		for (int k = 0; k < `KER_N; k++) begin
			sum = sum + prod[k];
		end
	end

	assign scaled = sum >>> shift;

	always_ff @(posedge clk) begin
		conv_data <= scaled[`ACC_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			l1 <= 1'b0;
			conv_valid <= 1'b0;
			conv_last <= 1'b0;
		end else begin
			v1 <= win_valid;
			l1 <= win_last;
			conv_valid <= v1;
			conv_last <= l1;
		end
	end

endmodule

// ==== source/max_pool.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module max_pool (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 frame_start,
	input  cnn_pkg::pool_mode_t  pool_mode,
	input  logic                 conv_valid,
	input  logic                 conv_last,
	input  cnn_pkg::acc_t        conv_data,
	output logic                 res_valid,
	output logic                 res_last,
	output cnn_pkg::acc_t        res_data
);
	import cnn_pkg::*;

	localparam int OUT_W = `IMG_W - 2;   // Results per row
	localparam int HALF_W = OUT_W / 2;

	acc_t left;              // First of a horizontal pair
	acc_t pair_max;
	acc_t block_max;
	acc_t row_buf [HALF_W];  // Pair maxima of the even row
	logic [`COL_W-1:0] out_col;
	logic [`COL_W-2:0] pair_idx;
	logic row_odd;
	logic emit;

	assign pair_idx = out_col[`COL_W-1:1];
	assign pair_max = (conv_data > left) ? conv_data : left;
	assign block_max = (row_buf[pair_idx] > pair_max) ? row_buf[pair_idx] : pair_max;
	assign emit = conv_valid && (pool_mode == pool_none || (row_odd && out_col[0]));

	// Block parity
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_col <= '0;
			row_odd <= 1'b0;
			res_valid <= 1'b0;
			res_last <= 1'b0;
		end else begin
			res_valid <= emit;
			res_last <= emit && conv_last;
			if (frame_start) begin
				out_col <= '0;
				row_odd <= 1'b0;
			end else if (conv_valid) begin
				if (out_col == OUT_W - 1) begin
					out_col <= '0;
					row_odd <= !row_odd;
				end else begin
					out_col <= out_col + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (conv_valid) begin
			if (!out_col[0])
				left <= conv_data;
			else if (!row_odd)
				row_buf[pair_idx] <= pair_max;
		end
		if (emit)
			res_data <= (pool_mode == pool_max) ? block_max : conv_data;
	end

endmodule

// ==== source/hwcnn_top.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module hwcnn_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [`INST_W-1:0]  instruct,
	input  logic                inst_empty,
	output logic                inst_req,
	input  logic                pix_valid,
	input  cnn_pkg::pixel_t     pix_data,
	output logic                pix_ready,
	output logic                res_valid,
	output cnn_pkg::acc_t       res_data,
	output logic                res_last,
	output logic                frame_done
);
	import cnn_pkg::*;

	// Decoder to datapath
	logic frame_start;
	pool_mode_t pool_mode;
	logic [`ROW_W-1:0] rows;
	logic wgt_we;
	logic [3:0] wgt_idx;
	weight_t wgt_value;
	logic bias_we;
	bias_t bias_value;
	shift_t shift_value;

	weight_t weights [`KER_N];
	bias_t bias;
	shift_t shift;

	logic win_valid;
	logic win_last;
	pixel_t window [3][3];

	logic conv_valid;
	logic conv_last;
	acc_t conv_data;

	//////////////////////////////
	inst_decoder u_dec (
		.clk(clk), .rst_n(rst_n),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.pix_valid(pix_valid), .pix_ready(pix_ready), .res_last(res_last),
		.frame_start(frame_start), .pool_mode(pool_mode), .rows(rows),
		.wgt_we(wgt_we), .wgt_idx(wgt_idx), .wgt_value(wgt_value),
		.bias_we(bias_we), .bias_value(bias_value), .shift_value(shift_value),
		.frame_done(frame_done)
	);

	kernel_buffer u_kbuf (
		.clk(clk), .rst_n(rst_n),
		.wgt_we(wgt_we), .wgt_idx(wgt_idx), .wgt_value(wgt_value),
		.bias_we(bias_we), .bias_value(bias_value), .shift_value(shift_value),
		.weights(weights), .bias(bias), .shift(shift)
	);

	//////////////////////////////
	// Feature-map pipeline
	line_window u_win (
		.clk(clk), .rst_n(rst_n), .frame_start(frame_start),
		.pix_ready(pix_ready), .pix_valid(pix_valid), .pix_data(pix_data),
		.rows(rows), .win_valid(win_valid), .win_last(win_last), .window(window)
	);

	conv_engine u_conv (
		.clk(clk), .rst_n(rst_n),
		.win_valid(win_valid), .win_last(win_last), .window(window),
		.weights(weights), .bias(bias), .shift(shift),
		.conv_valid(conv_valid), .conv_last(conv_last), .conv_data(conv_data)
	);

	max_pool u_pool (
		.clk(clk), .rst_n(rst_n), .frame_start(frame_start), .pool_mode(pool_mode),
		.conv_valid(conv_valid), .conv_last(conv_last), .conv_data(conv_data),
		.res_valid(res_valid), .res_last(res_last), .res_data(res_data)
	);

endmodule

// ==== sim/tb_hwcnn.sv ====
`timescale 1ns/1ps
`include "cnn_cfg.svh"

module tb_hwcnn;
	import cnn_pkg::*;

	localparam int TOTAL_PIX = 320;   // Pixels over all frames
	localparam int TOTAL_INST = 68;   // Instructions over all tests
	localparam int MAX_CYCLES = 4 * (TOTAL_PIX + TOTAL_INST);

	logic clk;
	logic rst_n;
	logic [`INST_W-1:0] instruct;
	logic inst_empty;
	logic inst_req;
	logic pix_valid;
	pixel_t pix_data;
	logic pix_ready;
	logic res_valid;
	acc_t res_data;
	logic res_last;
	logic frame_done;

	logic [`INST_W-1:0] inst_q [$];
	int pix_q [$];
	acc_t exp_q [$];
	bit exp_last_q [$];

	int img [0:16*`IMG_W-1];  // Row-major index r*IMG_W + c
	int model_w [`KER_N];
	int model_b;
	int model_s;

	int seed;
	int errors;
	int checks;
	int tests_run;
	int tests_failed;
	int cycles;
	int frames_queued;
	int frames_done;
	int lasts_seen;
	int junk_left;
	logic junk_now;
	logic last_d;
	logic busy;
	acc_t exp_v;
	bit exp_l;

	hwcnn_top uut (
		.clk(clk), .rst_n(rst_n),
		.instruct(instruct), .inst_empty(inst_empty), .inst_req(inst_req),
		.pix_valid(pix_valid), .pix_data(pix_data), .pix_ready(pix_ready),
		.res_valid(res_valid), .res_data(res_data), .res_last(res_last),
		.frame_done(frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	//////////////////////////////
	// Instruction FIFO and pixel source

	always @(posedge clk) begin
		if (!rst_n) begin
			inst_empty <= 1'b1;
		end else begin
			if (inst_req && inst_q.size() > 0)
				instruct <= inst_q.pop_front();  // Valid the cycle after inst_req
			inst_empty <= (inst_q.size() == 0);
		end
	end

	always @(posedge clk) begin
		if (!rst_n) begin
			pix_valid <= 1'b0;
			junk_now <= 1'b0;
		end else begin
			assert (!(pix_ready && pix_q.size() == 0)) else begin
				$display("pix_ready was high with no frame pixels left to take");
				errors++;
			end
			if (pix_valid && pix_ready && !junk_now)
				void'(pix_q.pop_front());
			if (pix_q.size() > 0) begin
				pix_valid <= 1'b1;
				pix_data <= pix_q[0];
				junk_now <= 1'b0;
			end else if (junk_left > 0) begin
				pix_valid <= 1'b1;  // Offered while idle
				pix_data <= {$random(seed)} % 256;
				junk_now <= 1'b1;
				junk_left <= junk_left - 1;
			end else begin
				pix_valid <= 1'b0;
				junk_now <= 1'b0;
			end
		end
	end

	//////////////////////////////
	// Result monitor

	always @(posedge clk) begin
		if (rst_n) begin
			if (res_valid) begin
				checks++;
				assert (exp_q.size() > 0) else begin
					$display("Unexpected result 0x%h with nothing expected", res_data);
					errors++;
				end
				if (exp_q.size() > 0) begin
					exp_v = exp_q.pop_front();
					exp_l = exp_last_q.pop_front();
					assert (res_data === exp_v) else begin
						$display("Mismatch res_data: got 0x%h, expected 0x%h", res_data, exp_v);
						errors++;
					end
					assert (res_last === exp_l) else begin
						$display("Mismatch res_last: got 0x%h, expected 0x%h", res_last, exp_l);
						errors++;
					end
				end
			end else begin
				assert (res_last !== 1'b1) else begin
					$display("res_last was raised without res_valid");
					errors++;
				end
			end
			assert (frame_done === last_d) else begin
				$display("frame_done did not follow res_last by one cycle");
				errors++;
			end
			assert (!(inst_req && busy)) else begin
				$display("inst_req pulsed while a frame was running");
				errors++;
			end
			if (frame_done)
				frames_done++;
			if (res_last)
				lasts_seen++;
			if (pix_ready)
				busy = 1'b1;
			else if (frame_done)
				busy = 1'b0;
			last_d = res_last;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, a frame never completed", cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	//////////////////////////////
	// Instruction encoding and reference model

	task automatic queue_kernel();
		logic [`INST_W-1:0] w;
		for (int k = 0; k < `KER_N; k++) begin
			w = '0;
			w[31:30] = op_load_weight;
			w[27:24] = k;
			w[7:0] = model_w[k];
			inst_q.push_back(w);
		end
		w = '0;
		w[31:30] = op_load_bias;
		w[24:20] = model_s;
		w[19:0] = model_b;
		inst_q.push_back(w);
	endtask

	// Valid conv over img and optional 2x2 max pooling
	task automatic add_frame(input int rows, input bit pooled);
		acc_t res [0:15][0:`IMG_W-1];
		longint sum;
		longint scaled;
		acc_t m;
		int n_res;
		int cnt;
		logic [`INST_W-1:0] w;
		w = '0;
		w[31:30] = op_conv;
		w[16] = pooled;
		w[15:0] = rows;
		inst_q.push_back(w);
		for (int i = 0; i < rows * `IMG_W; i++)
			pix_q.push_back(img[i]);
		for (int r = 2; r < rows; r++) begin
			for (int c = 2; c < `IMG_W; c++) begin
				sum = model_b;
				for (int k = 0; k < `KER_N; k++)
					sum += img[(r - 2 + k / 3) * `IMG_W + c - 2 + k % 3] * model_w[k];
				scaled = sum >>> model_s;
				res[r - 2][c - 2] = scaled[`ACC_W-1:0];
			end
		end
		cnt = 0;
		if (pooled) begin
			n_res = (rows - 2) / 2 * ((`IMG_W - 2) / 2);
			for (int r = 0; r < rows - 2; r += 2) begin
				for (int c = 0; c < `IMG_W - 2; c += 2) begin
					m = res[r][c];
					if (res[r][c + 1] > m) m = res[r][c + 1];
					if (res[r + 1][c] > m) m = res[r + 1][c];
					if (res[r + 1][c + 1] > m) m = res[r + 1][c + 1];
					cnt++;
					exp_q.push_back(m);
					exp_last_q.push_back(cnt == n_res);
				end
			end
		end else begin
			n_res = (rows - 2) * (`IMG_W - 2);
			for (int r = 0; r < rows - 2; r++) begin
				for (int c = 0; c < `IMG_W - 2; c++) begin
					cnt++;
					exp_q.push_back(res[r][c]);
					exp_last_q.push_back(cnt == n_res);
				end
			end
		end
		frames_queued++;
	endtask

	task automatic randomize_kernel();
		for (int k = 0; k < `KER_N; k++)
			model_w[k] = $random(seed) % 128;
		model_b = $random(seed) % (1 << 19);
		model_s = {$random(seed)} % 8;
	endtask

	task automatic randomize_image(input int rows);
		for (int i = 0; i < rows * `IMG_W; i++)
			img[i] = {$random(seed)} % 256;
	endtask

	task automatic finish_test(input string name, input int err0);
		wait (frames_done >= frames_queued);
		@(posedge clk);
		assert (exp_q.size() == 0) else begin
			$display("%0d expected results never arrived", exp_q.size());
			errors++;
		end
		assert (lasts_seen == frames_queued) else begin
			$display("res_last was seen %0d times for %0d frames", lasts_seen, frames_queued);
			errors++;
		end
		tests_run++;
		if (errors != err0)
			tests_failed++;
		$display("%-32s %s", name, (errors == err0) ? "ok" : "errors");
	endtask

	//////////////////////////////
	// Directed tests

	task automatic unpooled_ramp();
		int err0;
		err0 = errors;
		for (int k = 0; k < `KER_N; k++)
			model_w[k] = k + 1;
		model_b = 100;
		model_s = 2;
		for (int i = 0; i < 6 * `IMG_W; i++)
			img[i] = i;
		queue_kernel();
		add_frame(6, 1'b0);
		finish_test("Test 1 unpooled ramp", err0);
	endtask

	task automatic pooled_frame();
		int err0;
		err0 = errors;
		for (int k = 0; k < `KER_N; k++)
			model_w[k] = (k % 2) ? -(k + 1) : k + 1;
		model_b = 50;
		model_s = 1;
		for (int r = 0; r < 8; r++)
			for (int c = 0; c < `IMG_W; c++)
				img[r * `IMG_W + c] = (r * 37 + c * 11) % 256;
		queue_kernel();
		add_frame(8, 1'b1);
		finish_test("Test 2 pooled 8 rows", err0);
	endtask

	task automatic signed_shift();
		int err0;
		err0 = errors;
		model_w = '{-3, -7, 5, -11, -2, 9, -128, 4, -1};
		model_b = -1000;
		model_s = 3;
		for (int r = 0; r < 4; r++)
			for (int c = 0; c < `IMG_W; c++)
				img[r * `IMG_W + c] = 255 - (r * 29 + c * 17) % 256;
		queue_kernel();
		add_frame(4, 1'b0);
		finish_test("Test 3 negative and shifted", err0);
	endtask

	task automatic ignore_and_back_to_back();
		int err0;
		err0 = errors;
		junk_left = 6;
		wait (junk_left == 0);
		@(posedge clk);
		randomize_kernel();
		queue_kernel();
		inst_q.push_back('0);  // op_nop
		randomize_image(4);
		add_frame(4, 1'b0);
		randomize_image(6);
		add_frame(6, 1'b1);
		finish_test("Test 4 ignored strobes, two frames", err0);
	endtask

	task automatic random_frames();
		int err0;
		err0 = errors;
		randomize_kernel();
		queue_kernel();
		randomize_image(6);
		add_frame(6, 1'b0);
		randomize_kernel();
		queue_kernel();
		randomize_image(6);
		add_frame(6, 1'b1);
		finish_test("Test 5 random, both modes", err0);
	endtask

	initial begin
		seed = 68628;
		rst_n = 1'b0;
		instruct = '0;
		inst_empty = 1'b1;
		pix_valid = 1'b0;
		pix_data = '0;
		junk_left = 0;
		last_d = 1'b0;
		busy = 1'b0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		unpooled_ramp();
		pooled_frame();
		signed_shift();
		ignore_and_back_to_back();
		random_frames();
		$display("Tests %0d, failed %0d, results checked %0d, errors %0d",
			tests_run, tests_failed, checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+source
source/cnn_pkg.sv
source/inst_decoder.sv
source/kernel_buffer.sv
source/line_window.sv
source/conv_engine.sv
source/max_pool.sv
source/hwcnn_top.sv
sim/tb_hwcnn.sv
